// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = dab_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/dab_cfg.svh
// PWM register bank address map, channel count and control words
`ifndef DAB_CFG_SVH
`define DAB_CFG_SVH

`define PWM_BASE_ADDR   32'h4000_0000
`define N_PWM_CHANNELS  4

// Register offsets inside the PWM bank
`define CTRL_OFFSET     32'h0000_0000
`define COMPARE_OFFSET  32'h0000_0100
`define DEADTIME_OFFSET (32'h100 + 32'd4 * (2 * `N_PWM_CHANNELS))
`define PERIOD_OFFSET   (32'h100 + 32'd4 * (3 * `N_PWM_CHANNELS + 1))
`define GLOBAL_OFFSET_0 (32'h100 + 32'd4 * (3 * `N_PWM_CHANNELS + 5))
`define GLOBAL_OFFSET_1 (32'h100 + 32'd4 * (3 * `N_PWM_CHANNELS + 4))
`define GLOBAL_OFFSET_2 (32'h100 + 32'd4 * (3 * `N_PWM_CHANNELS + 3))

// Global configuration data, written in order 0 to 3
`define GLOBAL_DATA_0   32'h0000_0000
`define GLOBAL_DATA_1   32'h0000_0001
`define GLOBAL_DATA_2   32'h0000_000F
`define GLOBAL_DATA_3   32'h0000_00FF

`define START_WORD      32'h0000_0028
`define STOP_WORD       32'h0000_0000

`endif

// File: verif/dab_props.sv
// Bound assertions on the AXI4-Lite write channels, the command handshake and done
module dab_props (
    input logic        clock,
    input logic        reset,
    input logic        command_valid,
    input logic        command_ready,
    input logic        done,
    input logic        awvalid,
    input logic [31:0] awaddr,
    input logic        awready,
    input logic        wvalid,
    input logic [31:0] wdata,
    input logic        wready,
    input logic        bvalid,
    input logic        bready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic busy;
    int   failures = 0;

    // A command is in progress from its acceptance until done
    always_ff @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
        end else if (command_valid && command_ready) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    aw_hold: assert property (@(posedge clock) disable iff (!reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            failures++;
            $error("awvalid dropped or awaddr changed before awready");
        end

    w_hold: assert property (@(posedge clock) disable iff (!reset)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else begin
            failures++;
            $error("wvalid dropped or wdata changed before wready");
        end

    b_hold: assert property (@(posedge clock) disable iff (!reset)
        bready && !bvalid |=> bready)
        else begin
            failures++;
            $error("bready dropped before bvalid");
        end

    busy_not_ready: assert property (@(posedge clock) disable iff (!reset)
        busy |-> !command_ready)
        else begin
            failures++;
            $error("command_ready high while a command is in progress");
        end

    done_pulse: assert property (@(posedge clock) disable iff (!reset)
        done |=> !done)
        else begin
            failures++;
            $error("done stayed high for more than one cycle");
        end

endmodule

// File: verif/dab_tb.sv
// Testbench for the DAB modulation controller with AXI4-Lite slave model and directed tests
`include "dab_cfg.svh"

module dab_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCEPT_TIMEOUT = 1000;
    localparam int DONE_TIMEOUT   = 2000;

    logic                        clock = 1'b0;
    logic                        reset;
    logic                        command_valid;
    dab_pkg::command_e           command;
    dab_pkg::modulation_params_t params;
    logic                        command_ready;
    logic                        done;
    logic                        modulator_on;
    logic                        awvalid;
    logic [31:0]                 awaddr;
    logic [2:0]                  awprot;
    logic                        awready = 1'b0;
    logic                        wvalid;
    logic [31:0]                 wdata;
    logic [3:0]                  wstrb;
    logic                        wready = 1'b0;
    logic                        bvalid = 1'b0;
    logic [1:0]                  bresp = 2'b00;
    logic                        bready;

    dab_pkg::write_request_t write_log [$];
    dab_pkg::write_request_t expected_writes [$];
    dab_pkg::write_request_t logged_write;
    logic [15:0]             lfsr_state = 16'd59;
    logic                    stall_enable = 1'b0;
    logic                    aw_seen = 1'b0;
    logic                    w_seen = 1'b0;
    logic                    busy = 1'b0;

    dab_modulation_controller dut (.*);

    bind dab_modulation_controller dab_props props (
        .clock         (clock),
        .reset         (reset),
        .command_valid (command_valid),
        .command_ready (command_ready),
        .done          (done),
        .awvalid       (awvalid),
        .awaddr        (awaddr),
        .awready       (awready),
        .wvalid        (wvalid),
        .wdata         (wdata),
        .wready        (wready),
        .bvalid        (bvalid),
        .bready        (bready)
    );

    always #10 clock = ~clock;

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic report_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Slave model logs each write once both its address and data are in
    always @(posedge clock) begin
        if (!reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_seen = 1'b0;
            w_seen  = 1'b0;
        end else begin
            if (awvalid && awready) begin
                check_prot(3'b000, awprot);
                logged_write.addr = awaddr;
                aw_seen = 1'b1;
            end
            if (wvalid && wready) begin
                check_strobe(4'hF, wstrb);
                logged_write.data = wdata;
                w_seen = 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (aw_seen && w_seen) begin
                write_log.push_back(logged_write);
                aw_seen = 1'b0;
                w_seen  = 1'b0;
                bvalid <= 1'b1;
            end
            if (stall_enable) begin
                lfsr_state = lfsr_step(lfsr_state);
                awready <= lfsr_state[0];
                lfsr_state = lfsr_step(lfsr_state);
                wready <= lfsr_state[0];
            end else begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
        end
    end

    // Only one command may be accepted between two done pulses
    always @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
        end else begin
            if (done) begin
                busy <= 1'b0;
            end
            if (command_valid && command_ready) begin
                if (busy) begin
                    $display("A command was accepted while another one was still running");
                    report_failure();
                end
                busy <= 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        if (dut.props.failures != 0) begin
            $display("A bound assertion failed");
            report_failure();
        end
    end

    task automatic check_write(input dab_pkg::write_request_t exp_write,
                               input dab_pkg::write_request_t act_write, input int index);
        if (act_write !== exp_write) begin
            $display("MISMATCH write_log[%0d] addr %h data %h, expected addr %h data %h",
                     index, act_write.addr, act_write.data, exp_write.addr, exp_write.data);
            report_failure();
        end
    endtask

    task automatic check_status(input logic exp_on, input logic act_on);
        if (act_on !== exp_on) begin
            $display("MISMATCH modulator_on got %h, expected %h", act_on, exp_on);
            report_failure();
        end
    endtask

    task automatic check_count(input int exp_count, input int act_count);
        if (act_count != exp_count) begin
            $display("MISMATCH write count got %h, expected %h", act_count, exp_count);
            report_failure();
        end
    endtask

    task automatic check_prot(input logic [2:0] exp_prot, input logic [2:0] act_prot);
        if (act_prot !== exp_prot) begin
            $display("MISMATCH awprot got %h, expected %h", act_prot, exp_prot);
            report_failure();
        end
    endtask

    task automatic check_strobe(input logic [3:0] exp_strb, input logic [3:0] act_strb);
        if (act_strb !== exp_strb) begin
            $display("MISMATCH wstrb got %h, expected %h", act_strb, exp_strb);
            report_failure();
        end
    endtask

    function automatic dab_pkg::modulation_params_t build_params(
        input dab_pkg::modulation_e modulation, input int period, input int duty_1,
        input int phase_shift_1, input int phase_shift_2, input int deadtime);
        dab_pkg::modulation_params_t p;
        p.modulation    = modulation;
        p.period        = 16'(period);
        p.duty_1        = 16'(duty_1);
        p.duty_2        = 16'h5A5A;
        p.phase_shift_1 = 16'(phase_shift_1);
        p.phase_shift_2 = 16'(phase_shift_2);
        p.deadtime      = 16'(deadtime);
        return p;
    endfunction

    // Halves truncate toward zero, legs 2 and 3 add the duty, odd legs add the shift
    function automatic logic [15:0] expected_compare(input dab_pkg::modulation_params_t p,
                                                     input int k);
        int half_p;
        int half_d;
        int half_1;
        int half_2;
        int value;
        half_p = int'(p.period) / 2;
        half_d = int'(p.duty_1) / 2;
        half_1 = int'($signed(p.phase_shift_1)) / 2;
        half_2 = int'($signed(p.phase_shift_2)) / 2;
        value  = ((k / 2) >= 2) ? half_p + half_d : half_p - half_d;
        value  = ((k / 2) % 2 == 1) ? value + half_1 : value - half_1;
        if (p.modulation == dab_pkg::extended_phase_shift) begin
            value = (k % 2 == 0) ? value - half_2 : value + half_2;
        end
        return value[15:0];
    endfunction

    function automatic dab_pkg::write_request_t make_write(input logic [31:0] offset,
                                                           input logic [31:0] data);
        dab_pkg::write_request_t w;
        w.addr = `PWM_BASE_ADDR + offset;
        w.data = data;
        return w;
    endfunction

    task automatic add_compare_writes(input dab_pkg::modulation_params_t p);
        expected_writes.push_back(make_write(`PERIOD_OFFSET, {16'h0000, p.period}));
        for (int k = 0; k < 8; k++) begin
            expected_writes.push_back(make_write(`COMPARE_OFFSET + 32'(4 * k),
                                                 {16'h0000, expected_compare(p, k)}));
        end
    endtask

    task automatic add_start_writes(input dab_pkg::modulation_params_t p);
        for (int c = 0; c < `N_PWM_CHANNELS; c++) begin
            expected_writes.push_back(make_write(`DEADTIME_OFFSET + 32'(4 * c),
                                                 {16'h0000, p.deadtime}));
        end
        add_compare_writes(p);
        expected_writes.push_back(make_write(`CTRL_OFFSET, `START_WORD));
    endtask

    task automatic compare_log();
        check_count(expected_writes.size(), write_log.size());
        foreach (expected_writes[i]) begin
            check_write(expected_writes[i], write_log[i], i);
        end
        write_log.delete();
        expected_writes.delete();
    endtask

    task automatic issue_command(input dab_pkg::command_e op,
                                 input dab_pkg::modulation_params_t p);
        command_valid <= 1'b1;
        command       <= op;
        params        <= p;
    endtask

    task automatic wait_accept();
        int   cycles;
        logic accepted;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clock);
            if (command_valid && command_ready) begin
                accepted = 1'b1;
            end else if (cycles == ACCEPT_TIMEOUT) begin
                $display("Timed out waiting for the command to be accepted");
                report_failure();
            end else begin
                cycles++;
            end
        end
    endtask

    task automatic wait_done();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clock);
            if (done) begin
                seen = 1'b1;
            end else if (cycles == DONE_TIMEOUT) begin
                $display("Timed out waiting for done");
                report_failure();
            end else begin
                cycles++;
            end
        end
    endtask

    task automatic run_command(input dab_pkg::command_e op,
                               input dab_pkg::modulation_params_t p);
        issue_command(op, p);
        wait_accept();
        command_valid <= 1'b0;
        wait_done();
    endtask

    task automatic test_idle_and_configure();
        repeat (10) @(posedge clock);
        check_count(0, write_log.size());
        check_status(1'b0, modulator_on);
        expected_writes.push_back(make_write(`CTRL_OFFSET, `GLOBAL_DATA_0));
        expected_writes.push_back(make_write(`GLOBAL_OFFSET_0, `GLOBAL_DATA_1));
        expected_writes.push_back(make_write(`GLOBAL_OFFSET_1, `GLOBAL_DATA_2));
        expected_writes.push_back(make_write(`GLOBAL_OFFSET_2, `GLOBAL_DATA_3));
        run_command(dab_pkg::cmd_configure, '0);
        compare_log();
        check_status(1'b0, modulator_on);
    endtask

    task automatic test_start_single();
        dab_pkg::modulation_params_t p;
        p = build_params(dab_pkg::single_phase_shift, 1000, 401, -151, 60, 25);
        add_start_writes(p);
        run_command(dab_pkg::cmd_start, p);
        compare_log();
        check_status(1'b1, modulator_on);
    endtask

    task automatic test_update_extended();
        dab_pkg::modulation_params_t p;
        p = build_params(dab_pkg::extended_phase_shift, 2000, 600, 301, -77, 90);
        add_compare_writes(p);
        run_command(dab_pkg::cmd_update, p);
        compare_log();
        check_status(1'b1, modulator_on);
    endtask

    task automatic test_stop_then_update();
        expected_writes.push_back(make_write(`CTRL_OFFSET, `STOP_WORD));
        run_command(dab_pkg::cmd_stop, '0);
        compare_log();
        check_status(1'b0, modulator_on);
        run_command(dab_pkg::cmd_update,
                    build_params(dab_pkg::single_phase_shift, 800, 200, 40, 0, 10));
        compare_log();
        check_status(1'b0, modulator_on);
    endtask

    // The update is offered while the start is still running and must wait for it
    task automatic test_random_stalls();
        dab_pkg::modulation_params_t first;
        dab_pkg::modulation_params_t second;
        first  = build_params(dab_pkg::extended_phase_shift, 500, 900, -333, 1201, 40);
        second = build_params(dab_pkg::single_phase_shift, 3000, 1234, 777, 0, 40);
        stall_enable <= 1'b1;
        add_start_writes(first);
        add_compare_writes(second);
        issue_command(dab_pkg::cmd_start, first);
        wait_accept();
        issue_command(dab_pkg::cmd_update, second);
        wait_done();
        wait_accept();
        command_valid <= 1'b0;
        wait_done();
        compare_log();
        check_status(1'b1, modulator_on);
        stall_enable <= 1'b0;
    endtask

    initial begin
        reset         = 1'b0;
        command_valid = 1'b0;
        command       = dab_pkg::cmd_configure;
        params        = '0;
        repeat (16) @(posedge clock);
        reset <= 1'b1;
        test_idle_and_configure();
        test_start_single();
        test_update_extended();
        test_stop_then_update();
        test_random_stalls();
        repeat (4) @(posedge clock);
        if (dut.props.failures == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", dut.props.failures);
            report_failure();
        end
    end

endmodule

// File: verilog/axi_lite_write_master.sv
// AXI4-Lite write master that issues one register write at a time
module axi_lite_write_master (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    req_valid,
    input  dab_pkg::write_request_t req,
    output logic                    req_ready,
    output logic                    awvalid,
    output logic [31:0]             awaddr,
    output logic [2:0]              awprot,
    input  logic                    awready,
    output logic                    wvalid,
    output logic [31:0]             wdata,
    output logic [3:0]              wstrb,
    input  logic                    wready,
    input  logic                    bvalid,
    // The response code is not inspected, every write counts as complete
    input  logic [1:0]              bresp,
    output logic                    bready
);

    typedef enum logic [1:0] {
        idle,
        address_data,
        response
    } state_e;

    state_e state;
    logic   aw_accepted;
    logic   w_accepted;

    assign req_ready = (state == idle);
    assign awprot    = 3'b000;
    assign wstrb     = 4'hF;

    // Each channel is finished once its valid has dropped or its ready is seen
    assign aw_accepted = !awvalid || awready;
    assign w_accepted  = !wvalid || wready;

    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            awaddr <= req.addr;
            wdata  <= req.data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state   <= idle;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (req_valid) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= address_data;
                    end
                end
                address_data: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (aw_accepted && w_accepted) begin
                        bready <= 1'b1;
                        state  <= response;
                    end
                end
                response: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        state  <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: verilog/dab_modulation_controller.sv
// Top level of the DAB pre-modulation controller with calculator, sequencer and AXI master
module dab_modulation_controller (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        command_valid,
    input  dab_pkg::command_e           command,
    input  dab_pkg::modulation_params_t params,
    output logic                        command_ready,
    output logic                        done,
    output logic                        modulator_on,
    output logic                        awvalid,
    output logic [31:0]                 awaddr,
    output logic [2:0]                  awprot,
    input  logic                        awready,
    output logic                        wvalid,
    output logic [31:0]                 wdata,
    output logic [3:0]                  wstrb,
    input  logic                        wready,
    input  logic                        bvalid,
    input  logic [1:0]                  bresp,
    output logic                        bready
);

    logic                        calc_start;
    logic                        calc_valid;
    dab_pkg::modulation_params_t calc_params;
    dab_pkg::compare_set_t       compares;
    logic                        req_valid;
    logic                        req_ready;
    dab_pkg::write_request_t     req;

    phase_shift_calculator calculator (
        .clock      (clock),
        .reset      (reset),
        .calc_start (calc_start),
        .params     (calc_params),
        .calc_valid (calc_valid),
        .compares   (compares)
    );

    register_sequencer sequencer (
        .clock         (clock),
        .reset         (reset),
        .command_valid (command_valid),
        .command       (command),
        .params        (params),
        .calc_valid    (calc_valid),
        .compares      (compares),
        .req_ready     (req_ready),
        .command_ready (command_ready),
        .done          (done),
        .modulator_on  (modulator_on),
        .calc_start    (calc_start),
        .calc_params   (calc_params),
        .req_valid     (req_valid),
        .req           (req)
    );

    axi_lite_write_master write_master (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .awprot    (awprot),
        .awready   (awready),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wready    (wready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .bready    (bready)
    );

endmodule

// File: verilog/dab_pkg.sv
// Modulation and command enums, parameter set, compare set and write request structs
package dab_pkg;

    typedef enum logic [1:0] {
        single_phase_shift   = 2'd0,
        extended_phase_shift = 2'd1,
        reserved_2           = 2'd2,
        reserved_3           = 2'd3
    } modulation_e;

    // Opcodes 4 to 7 are not assigned and complete without any write
    typedef enum logic [2:0] {
        cmd_configure = 3'd0,
        cmd_start     = 3'd1,
        cmd_update    = 3'd2,
        cmd_stop      = 3'd3
    } command_e;

    // Modulation parameters as sampled on command acceptance
    typedef struct packed {
        modulation_e        modulation;
        logic        [15:0] period;
        logic        [15:0] duty_1;
        // Second duty is carried along but no modulation uses it yet
        logic        [15:0] duty_2;
        logic signed [15:0] phase_shift_1;
        logic signed [15:0] phase_shift_2;
        logic        [15:0] deadtime;
    } modulation_params_t;

    // Period word and the eight compare values of the four PWM channels
    typedef struct packed {
        logic [15:0]      period;
        logic [7:0][15:0] compare;
    } compare_set_t;

    // One register write towards the PWM bank
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } write_request_t;

endpackage

// File: verilog/phase_shift_calculator.sv
// Two stage compare value calculator for single and extended phase-shift modulation
module phase_shift_calculator (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        calc_start,
    input  dab_pkg::modulation_params_t params,
    output logic                        calc_valid,
    output dab_pkg::compare_set_t       compares
);

    logic                 stage_valid;
    dab_pkg::modulation_e modulation_q;
    logic [15:0]          period_q;
    logic signed [16:0]   half_period;
    logic signed [16:0]   half_duty;
    logic signed [16:0]   half_shift_1;
    logic signed [16:0]   half_shift_2;
    logic signed [18:0]   edge_value [4];
    logic signed [18:0]   lead_value [4];
    logic signed [18:0]   lag_value [4];

    always_ff @(posedge clock) begin
        if (!reset) begin
            stage_valid <= 1'b0;
            calc_valid  <= 1'b0;
        end else begin
            stage_valid <= calc_start;
            calc_valid  <= stage_valid;
        end
    end

    // First stage halves the inputs, signed division rounds toward zero
    always_ff @(posedge clock) begin
        if (calc_start) begin
            modulation_q <= params.modulation;
            period_q     <= params.period;
            half_period  <= $signed({1'b0, params.period}) / 17'sd2;
            half_duty    <= $signed({1'b0, params.duty_1}) / 17'sd2;
            half_shift_1 <= $signed({params.phase_shift_1[15], params.phase_shift_1}) / 17'sd2;
            half_shift_2 <= $signed({params.phase_shift_2[15], params.phase_shift_2}) / 17'sd2;
        end
    end

    // Switching edges of the four legs, then the split for the second shift
    always_comb begin
        edge_value[0] = half_period - half_duty - half_shift_1;
        edge_value[1] = half_period - half_duty + half_shift_1;
        edge_value[2] = half_period + half_duty - half_shift_1;
        edge_value[3] = half_period + half_duty + half_shift_1;
        for (int k = 0; k < 4; k++) begin
            lead_value[k] = edge_value[k] - half_shift_2;
            lag_value[k]  = edge_value[k] + half_shift_2;
        end
    end

    // Second stage keeps the low 16 bits of every sum
    always_ff @(posedge clock) begin
        if (stage_valid) begin
            compares.period <= period_q;
            for (int k = 0; k < 4; k++) begin
                case (modulation_q)
                    dab_pkg::single_phase_shift: begin
                        compares.compare[2*k]   <= edge_value[k][15:0];
                        compares.compare[2*k+1] <= edge_value[k][15:0];
                    end
                    dab_pkg::extended_phase_shift: begin
                        compares.compare[2*k]   <= lead_value[k][15:0];
                        compares.compare[2*k+1] <= lag_value[k][15:0];
                    end
                    // Reserved types keep the previous compare values
                    default: begin
                        compares.compare[2*k]   <= compares.compare[2*k];
                        compares.compare[2*k+1] <= compares.compare[2*k+1];
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/register_sequencer.sv
// Command FSM that orders the PWM register writes and tracks the modulator status
`include "dab_cfg.svh"

module register_sequencer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        command_valid,
    input  dab_pkg::command_e           command,
    input  dab_pkg::modulation_params_t params,
    input  logic                        calc_valid,
    input  dab_pkg::compare_set_t       compares,
    input  logic                        req_ready,
    output logic                        command_ready,
    output logic                        done,
    output logic                        modulator_on,
    output logic                        calc_start,
    output dab_pkg::modulation_params_t calc_params,
    output logic                        req_valid,
    output dab_pkg::write_request_t     req
);

    typedef enum logic [2:0] {
        idle,
        global_config,
        deadtime_config,
        wait_calc,
        compare_writes,
        start_word,
        stop_word,
        finish
    } state_e;

    state_e      state;
    logic [3:0]  index;
    logic [3:0]  slot;
    logic        start_pending;
    logic        calc_done;
    logic        accept;
    logic        write_fire;

    assign command_ready = (state == idle);
    assign accept        = command_valid && command_ready;
    assign write_fire    = req_valid && req_ready;
    // The write master is ready again only once the last B response is in
    assign done          = (state == finish) && req_ready;
    assign slot          = index - 4'd1;

    always_ff @(posedge clock) begin
        if (accept) begin
            calc_params <= params;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state         <= idle;
            index         <= '0;
            start_pending <= 1'b0;
            calc_done     <= 1'b0;
            calc_start    <= 1'b0;
            modulator_on  <= 1'b0;
        end else begin
            calc_start <= 1'b0;
            if (calc_valid) begin
                calc_done <= 1'b1;
            end
            case (state)
                idle: begin
                    if (accept) begin
                        index     <= '0;
                        calc_done <= 1'b0;
                        case (command)
                            dab_pkg::cmd_configure: state <= global_config;
                            dab_pkg::cmd_start: begin
                                calc_start    <= 1'b1;
                                start_pending <= 1'b1;
                                state         <= deadtime_config;
                            end
                            dab_pkg::cmd_update: begin
                                calc_start <= modulator_on;
                                state      <= modulator_on ? wait_calc : finish;
                            end
                            dab_pkg::cmd_stop: state <= stop_word;
                            default: state <= finish;
                        endcase
                    end
                end
                global_config: begin
                    if (write_fire) begin
                        index <= index + 4'd1;
                        if (index == 4'd3) begin
                            state <= finish;
                        end
                    end
                end
                deadtime_config: begin
                    if (write_fire) begin
                        index <= index + 4'd1;
                        if (index == 4'(`N_PWM_CHANNELS - 1)) begin
                            state <= wait_calc;
                        end
                    end
                end
                wait_calc: begin
                    if (calc_done || calc_valid) begin
                        index <= '0;
                        state <= compare_writes;
                    end
                end
                compare_writes: begin
                    if (write_fire) begin
                        index <= index + 4'd1;
                        if (index == 4'd8) begin
                            state <= start_pending ? start_word : finish;
                        end
                    end
                end
                start_word: begin
                    if (write_fire) begin
                        modulator_on  <= 1'b1;
                        start_pending <= 1'b0;
                        state         <= finish;
                    end
                end
                stop_word: begin
                    if (write_fire) begin
                        modulator_on <= 1'b0;
                        state        <= finish;
                    end
                end
                finish: begin
                    if (req_ready) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // Index 0 of the compare phase is the period word, 1 to 8 the compares
    always_comb begin
        req_valid = 1'b1;
        req.addr  = `PWM_BASE_ADDR + `CTRL_OFFSET;
        req.data  = '0;
        case (state)
            global_config: begin
                case (index[1:0])
                    2'd0: req.data = `GLOBAL_DATA_0;
                    2'd1: begin
                        req.addr = `PWM_BASE_ADDR + `GLOBAL_OFFSET_0;
                        req.data = `GLOBAL_DATA_1;
                    end
                    2'd2: begin
                        req.addr = `PWM_BASE_ADDR + `GLOBAL_OFFSET_1;
                        req.data = `GLOBAL_DATA_2;
                    end
                    default: begin
                        req.addr = `PWM_BASE_ADDR + `GLOBAL_OFFSET_2;
                        req.data = `GLOBAL_DATA_3;
                    end
                endcase
            end
            deadtime_config: begin
                req.addr = `PWM_BASE_ADDR + `DEADTIME_OFFSET + (32'(index) << 2);
                req.data = {16'h0000, calc_params.deadtime};
            end
            compare_writes: begin
                if (index == 4'd0) begin
                    req.addr = `PWM_BASE_ADDR + `PERIOD_OFFSET;
                    req.data = {16'h0000, compares.period};
                end else begin
                    req.addr = `PWM_BASE_ADDR + `COMPARE_OFFSET + (32'(slot) << 2);
                    req.data = {16'h0000, compares.compare[slot[2:0]]};
                end
            end
            start_word: req.data = `START_WORD;
            stop_word:  req.data = `STOP_WORD;
            default:    req_valid = 1'b0;
        endcase
    end

endmodule

// File: vlog.f
+incdir+include
verilog/dab_pkg.sv
verilog/phase_shift_calculator.sv
verilog/register_sequencer.sv
verilog/axi_lite_write_master.sv
verilog/dab_modulation_controller.sv
verif/dab_props.sv
verif/dab_tb.sv
